// File: dcache_top.f
design/dcache_pkg.sv
design/stream_if.sv
design/line_store.sv
design/stream_buffer.sv
design/stream_control.sv
design/miss_queue.sv
design/dcache_top.sv
tests/dcache_top_assert.sv
tests/dcache_top_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the cache testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f dcache_top.f \
  --top-module dcache_top_tb -o dcache_sim || { echo "build failed"; exit 1; }
out="$(./obj_dir/dcache_sim)"
echo "$out"
echo "$out" | grep -q "^Verification passed$" && echo "simulation ok" \
  || { echo "simulation not ok"; exit 1; }

// File: tests/dcache_top_input.txt
# op  address   value (R: expected data, W: stored data)
# unwritten lines read back as {line address, inverted line address}
W 00000040 1122334455667788
R 00000040 1122334455667788
R 00001000 00001000ffffefff
R 00001008 00001008ffffeff7
R 00001010 00001010ffffefef
R 0000101c 00001018ffffefe7
W 00000588 a5a5a5a5c3c3c3c3
R 00000588 a5a5a5a5c3c3c3c3
R 00002000 00002000ffffdfff
R 00003000 00003000ffffcfff
R 00004000 00004000ffffbfff
R 00005000 00005000ffffafff
R 00002008 00002008ffffdff7
R 00003008 00003008ffffcff7
R 00004008 00004008ffffbff7
R 00005008 00005008ffffaff7
R 00002010 00002010ffffdfef
R 00003010 00003010ffffcfef
R 00004010 00004010ffffbfef
R 00005010 00005010ffffafef

// File: tests/dcache_top_tb.sv
module dcache_top_tb
  import dcache_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ns;

  localparam int PERIOD          = 100;
  localparam int RESET_CYCLES    = 8;
  localparam int CYCLES_PER_LINE = 200;
  localparam int MEM_DELAY_MIN   = 3;

  int seed = 32'h3851_4f89;

  logic     clock;
  logic     reset;
  logic     rd_en;
  addr_t    rd_addr;
  data_t    rd_data;
  logic     rd_valid;
  logic     wr_en;
  addr_t    wr_addr;
  data_t    wr_data;
  logic     rd_miss_valid;
  addr_t    rd_miss_addr;
  data_t    rd_miss_data;
  bus_cmd_t mem_command;
  addr_t    mem_addr;
  mem_tag_t mem_response;
  data_t    mem_data;
  mem_tag_t mem_tag;

  // operations from the input file
  logic [7:0] ops [$];
  addr_t      op_addr [$];
  data_t      op_value [$];
  int         n_lines;
  bit         loaded;

  int errors;
  int miss_errors;

  // lines seen at the memory port, lines that pulsed rd_miss_valid
  bit presented [addr_t];
  bit miss_seen [addr_t];
  bit prefetch_due [addr_t];

  // per set, the line last written by a store
  bit    stored_valid [NUM_SETS];
  addr_t stored_at [NUM_SETS];

  dcache_top dcache_top_i (.*);

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  // line address in the upper half, its inverse in the lower half
  function automatic data_t memory_word(input addr_t addr);
    return {addr, ~addr};
  endfunction

  ////////////////////
  // memory model
  ////////////////////

  initial begin : memory_model
    addr_t    pend_addr [$];
    mem_tag_t pend_tag [$];
    int       pend_due [$];
    int       cycle;
    mem_tag_t next_tag;
    cycle        = 0;
    next_tag     = 4'd1;
    mem_response = '0;
    mem_data     = '0;
    mem_tag      = '0;
    forever begin
      @(negedge clock);
      cycle++;
      mem_response = '0;
      mem_tag      = '0;
      mem_data     = '0;
      if (reset === 1'b0) begin
        if (mem_command == BUS_LOAD) begin
          presented[mem_addr] = 1'b1;
          // roughly three loads in four are accepted
          if (($random(seed) & 3) != 0) begin
            mem_response = next_tag;
            pend_addr.push_back(mem_addr);
            pend_tag.push_back(next_tag);
            pend_due.push_back(cycle + MEM_DELAY_MIN + ($random(seed) & 3));
            next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
          end
        end
        // in order, one return per cycle
        if (pend_due.size() > 0 && pend_due[0] <= cycle) begin
          mem_tag  = pend_tag.pop_front();
          mem_data = memory_word(pend_addr.pop_front());
          void'(pend_due.pop_front());
        end
      end
    end
  end

  initial begin : miss_monitor
    forever begin
      @(posedge clock);
      if (reset === 1'b0 && rd_miss_valid === 1'b1) begin
        assert (rd_miss_data === memory_word(rd_miss_addr)) else begin
          miss_errors++;
          $display("** Error miss pulse at %h: expected %h, actual %h",
                   rd_miss_addr, memory_word(rd_miss_addr), rd_miss_data);
        end
        miss_seen[rd_miss_addr] = 1'b1;
      end
    end
  end

  initial begin : watchdog
    wait (loaded);
    repeat (CYCLES_PER_LINE * (n_lines + 1)) @(posedge clock);
    $display("watchdog expired before all operations finished");
    $display("Verification failed");
    $finish;
  end

  ////////////////////
  // stimulus
  ////////////////////

  task automatic load_ops();
    int         fd;
    int         code;
    string      text;
    logic [7:0] op;
    addr_t      addr;
    data_t      value;
    n_lines = 0;
    fd = $fopen("tests/dcache_top_input.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the operation file");
    end else begin
      while ($fgets(text, fd) != 0) begin
        n_lines++;
        code = $sscanf(text, "%s %h %h", op, addr, value);
        if (code == 3 && (op == "R" || op == "W")) begin
          ops.push_back(op);
          op_addr.push_back(addr);
          op_value.push_back(value);
        end
      end
      $fclose(fd);
    end
    loaded = 1'b1;
  endtask

  task automatic check_idle(input int cycle);
    assert (mem_command === BUS_NONE && rd_miss_valid === 1'b0) else begin
      errors++;
      $display("memory bus or miss strobe not idle at reset cycle %0d", cycle);
    end
  endtask

  task automatic write_line(input addr_t addr, input data_t value);
    set_idx_t set;
    set = addr[7:3];
    @(negedge clock);
    rd_en   = 1'b0;
    wr_en   = 1'b1;
    wr_addr = addr;
    wr_data = value;
    stored_valid[set] = 1'b1;
    stored_at[set]    = {addr[31:3], 3'b000};
  endtask

  task automatic read_line(input addr_t addr, input data_t expected, input int num);
    addr_t    line_addr;
    set_idx_t set;
    string    name;
    int       waited;
    bit       fresh;
    bit       same_cycle;
    line_addr  = {addr[31:3], 3'b000};
    set        = line_addr[7:3];
    name       = $sformatf("read %0d at %h", num, addr);
    same_cycle = stored_valid[set] && (stored_at[set] == line_addr);
    @(negedge clock);
    wr_en   = 1'b0;
    rd_en   = 1'b1;
    rd_addr = addr;
    waited  = 0;
    @(posedge clock);
    fresh = !presented.exists(line_addr) && !same_cycle;
    // the stream started by the last miss should already be fetching
    if (prefetch_due.exists(line_addr)) begin
      assert (presented.exists(line_addr)) else begin
        errors++;
        $display("%s: no prefetch load reached memory before this read", name);
      end
    end
    while (rd_valid !== 1'b1) begin
      waited++;
      @(posedge clock);
    end
    assert (rd_data === expected) else begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, expected, rd_data);
    end
    if (same_cycle) begin
      assert (waited == 0) else begin
        errors++;
        $display("** Error %s latency: expected 0, actual %0d", name, waited);
      end
    end
    if (fresh) begin
      assert (miss_seen.exists(line_addr)) else begin
        errors++;
        $display("%s: rd_miss_valid never pulsed for this line", name);
      end
      prefetch_due[line_addr + 32'd8] = 1'b1;
    end
    if (stored_at[set] != line_addr) stored_valid[set] = 1'b0;
  endtask

  initial begin : stimulus
    reset       = 1'b1;
    rd_en       = 1'b0;
    rd_addr     = '0;
    wr_en       = 1'b0;
    wr_addr     = '0;
    wr_data     = '0;
    errors      = 0;
    miss_errors = 0;
    loaded      = 1'b0;
    load_ops();
    @(posedge clock);
    // reset spans 8 edges, then one more check after release
    for (int c = 1; c < RESET_CYCLES + 2; c++) begin
      @(negedge clock);
      if (c == RESET_CYCLES) reset = 1'b0;
      @(posedge clock);
      check_idle(c);
    end
    for (int i = 0; i < ops.size(); i++) begin
      if (ops[i] == "W") write_line(op_addr[i], op_value[i]);
      else read_line(op_addr[i], op_value[i], i);
    end
    @(negedge clock);
    rd_en = 1'b0;
    wr_en = 1'b0;
    $display("errors: %0d in reads and reset, %0d in miss pulses", errors, miss_errors);
    if (errors == 0 && miss_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: tests/dcache_top_assert.sv
module dcache_top_assert
  import dcache_pkg::*;
(
  input logic     clock,
  input logic     reset,
  input bus_cmd_t mem_command,
  input addr_t    mem_addr,
  input mem_tag_t mem_response
);

  timeunit 1ns;
  timeprecision 1ns;

  // a refused load comes back unchanged in the next cycle
  refused_load_held: assert property (@(posedge clock) disable iff (reset)
    (mem_command == BUS_LOAD && mem_response == '0) |=>
      (mem_command == BUS_LOAD && $stable(mem_addr)))
    else $error("refused load at %h was not presented again", $past(mem_addr));

  // queue starts empty, so the bus is quiet right after reset
  idle_after_reset: assert property (@(posedge clock)
    ($past(reset) && !reset) |-> (mem_command == BUS_NONE))
    else $error("mem_command is not BUS_NONE in the first cycle after reset");

endmodule

bind dcache_top dcache_top_assert dcache_top_assert_i (
  .clock(clock),
  .reset(reset),
  .mem_command(mem_command),
  .mem_addr(mem_addr),
  .mem_response(mem_response)
);

// File: design/dcache_top.sv
module dcache_top
  import dcache_pkg::*;
#(
  parameter int NUM_BUFFERS  = 4,
  parameter int BUFFER_DEPTH = 4,
  parameter int QUEUE_DEPTH  = 8
) (
  input  logic     clock,
  input  logic     reset,
  input  logic     rd_en,
  input  addr_t    rd_addr,
  output data_t    rd_data,
  output logic     rd_valid,
  input  logic     wr_en,
  input  addr_t    wr_addr,
  input  data_t    wr_data,
  output logic     rd_miss_valid,
  output addr_t    rd_miss_addr,
  output data_t    rd_miss_data,
  output bus_cmd_t mem_command,
  output addr_t    mem_addr,
  input  mem_tag_t mem_response,
  input  data_t    mem_data,
  input  mem_tag_t mem_tag
);

  line_t rd_line;
  line_t wr_line;
  logic  rd_hit;
  logic  move_en;
  line_t move_line;
  data_t move_data;
  logic  fill_en;
  line_t fill_line;
  data_t fill_data;
  logic  miss_en;
  line_t miss_line;
  logic  miss_taken;

  // offset bits are dropped, the cache works on whole lines
  assign rd_line  = rd_addr[31:3];
  assign wr_line  = wr_addr[31:3];
  assign rd_valid = rd_en && rd_hit;

  stream_if #(.NUM_BUFFERS(NUM_BUFFERS)) streams ();

  line_store line_store_i (
    .clock, .reset,
    .rd_line, .wr_en, .wr_line, .wr_data,
    .move_en, .move_line, .move_data,
    .fill_en, .fill_line, .fill_data,
    .rd_hit, .rd_data
  );

  stream_control #(.NUM_BUFFERS(NUM_BUFFERS)) stream_control_i (
    .clock, .reset,
    .rd_en, .rd_line, .rd_hit, .miss_taken,
    .miss_en, .miss_line, .move_en, .move_line, .move_data,
    .sc(streams.control)
  );

  for (genvar b = 0; b < NUM_BUFFERS; b++) begin : g_buffer
    stream_buffer #(.BUFFER_DEPTH(BUFFER_DEPTH), .BUFFER_ID(b)) stream_buffer_i (
      .clock, .reset,
      .sb(streams.buffer)
    );
  end

  miss_queue #(.NUM_BUFFERS(NUM_BUFFERS), .QUEUE_DEPTH(QUEUE_DEPTH)) miss_queue_i (
    .clock, .reset,
    .miss_en, .miss_line, .mem_response, .mem_data, .mem_tag,
    .miss_taken, .mem_command, .mem_addr,
    .fill_en, .fill_line, .fill_data,
    .rd_miss_valid, .rd_miss_addr, .rd_miss_data,
    .sq(streams.queue)
  );

endmodule

// File: design/miss_queue.sv
module miss_queue
  import dcache_pkg::*;
#(
  parameter int NUM_BUFFERS = 4,
  parameter int QUEUE_DEPTH = 8
) (
  input  logic     clock,
  input  logic     reset,
  input  logic     miss_en,
  input  line_t    miss_line,
  input  mem_tag_t mem_response,
  input  data_t    mem_data,
  input  mem_tag_t mem_tag,
  output logic     miss_taken,
  output bus_cmd_t mem_command,
  output addr_t    mem_addr,
  output logic     fill_en,
  output line_t    fill_line,
  output data_t    fill_data,
  output logic     rd_miss_valid,
  output addr_t    rd_miss_addr,
  output data_t    rd_miss_data,
  stream_if.queue  sq
);

  localparam int PW = $clog2(QUEUE_DEPTH);
  localparam int CW = $clog2(QUEUE_DEPTH + 1);
  localparam int BW = $clog2(NUM_BUFFERS);

  ////////////////////
  // queue state
  ////////////////////

  logic [QUEUE_DEPTH-1:0] q_valid;
  logic [QUEUE_DEPTH-1:0] q_sent;
  logic [QUEUE_DEPTH-1:0] q_cache;
  logic [QUEUE_DEPTH-1:0] q_buf;
  line_t                  q_line [QUEUE_DEPTH];
  mem_tag_t               q_tag [QUEUE_DEPTH];
  logic [BW-1:0]          q_num [QUEUE_DEPTH];

  logic [PW-1:0] head;
  logic [PW-1:0] tail;
  logic [PW-1:0] send_ptr;
  logic [CW-1:0] count;
  logic [BW-1:0] rr_ptr;

  // registered fill, one cycle after the tag match
  logic          fill_cache_r;
  logic          fill_buf_r;
  logic [BW-1:0] fill_num_r;
  line_t         fill_line_r;
  data_t         fill_data_r;

  logic [QUEUE_DEPTH-1:0] match;
  logic                   absorbed;
  logic [NUM_BUFFERS-1:0] req_eff;
  logic                   grant_any;
  logic [BW-1:0]          grant_num;
  logic                   prefetch_go;
  logic [PW-1:0]          pf_slot;
  logic                   sending;
  logic                   accept;
  logic                   mem_done;

  function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
    return (p == PW'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // duplicate search, including a line whose fill is under way
  always_comb begin
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      match[i] = q_valid[i] && (q_line[i] == miss_line);
    end
  end

  assign absorbed   = (|match) || ((fill_cache_r || fill_buf_r) && fill_line_r == miss_line);
  assign miss_taken = miss_en && !absorbed && (count < CW'(QUEUE_DEPTH));

  // rotating pick among buffer requests, lowest offset from rr_ptr wins
  assign req_eff = sq.req & ~sq.alloc;

  always_comb begin
    logic [BW-1:0] cand;
    grant_any = 1'b0;
    grant_num = rr_ptr;
    for (int k = NUM_BUFFERS - 1; k >= 0; k--) begin
      cand = rr_ptr + BW'(k);
      if (req_eff[cand]) begin
        grant_any = 1'b1;
        grant_num = cand;
      end
    end
  end

  assign prefetch_go = grant_any && ((count + CW'(miss_taken)) < CW'(QUEUE_DEPTH));
  assign pf_slot     = miss_taken ? next_ptr(tail) : tail;
  assign sq.grant    = prefetch_go ? (NUM_BUFFERS'(1) << grant_num) : '0;

  // memory side
  assign sending     = q_valid[send_ptr] && !q_sent[send_ptr];
  assign accept      = sending && (mem_response != '0);
  assign mem_command = sending ? BUS_LOAD : BUS_NONE;
  assign mem_addr    = sending ? {q_line[send_ptr], 3'b000} : '0;
  assign mem_done    = q_valid[head] && q_sent[head] && (mem_tag != '0) &&
                       (q_tag[head] == mem_tag);

  assign fill_en       = fill_cache_r;
  assign fill_line     = fill_line_r;
  assign fill_data     = fill_data_r;
  assign sq.fill       = fill_buf_r ? (NUM_BUFFERS'(1) << fill_num_r) : '0;
  assign sq.fill_data  = fill_data_r;
  assign rd_miss_valid = fill_cache_r;
  assign rd_miss_addr  = {fill_line_r, 3'b000};
  assign rd_miss_data  = fill_data_r;

  always_ff @(posedge clock) begin
    if (reset) begin
      q_valid      <= '0;
      head         <= '0;
      tail         <= '0;
      send_ptr     <= '0;
      count        <= '0;
      rr_ptr       <= '0;
      fill_cache_r <= 1'b0;
      fill_buf_r   <= 1'b0;
    end else begin
      if (accept) send_ptr <= next_ptr(send_ptr);
      if (mem_done) begin
        q_valid[head] <= 1'b0;
        head          <= next_ptr(head);
      end
      if (miss_taken) q_valid[tail] <= 1'b1;
      if (prefetch_go) begin
        q_valid[pf_slot] <= 1'b1;
        rr_ptr           <= grant_num + 1'b1;
      end
      tail  <= prefetch_go ? next_ptr(pf_slot) : pf_slot;
      count <= count + CW'(miss_taken) + CW'(prefetch_go) - CW'(mem_done);
      // a miss on the retiring line still reaches the cache
      fill_cache_r <= mem_done && (q_cache[head] || (miss_en && match[head]));
      fill_buf_r   <= mem_done && q_buf[head] && !sq.alloc[q_num[head]];
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      q_sent[send_ptr] <= 1'b1;
      q_tag[send_ptr]  <= mem_response;
    end
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      if (miss_en && match[i]) q_cache[i] <= 1'b1;
      // a restarted buffer no longer wants its old lines
      if (q_valid[i] && sq.alloc[q_num[i]]) q_buf[i] <= 1'b0;
    end
    if (miss_taken) begin
      q_line[tail]  <= miss_line;
      q_sent[tail]  <= 1'b0;
      q_cache[tail] <= 1'b1;
      q_buf[tail]   <= 1'b0;
      q_num[tail]   <= '0;
    end
    if (prefetch_go) begin
      q_line[pf_slot]  <= sq.req_line[grant_num];
      q_sent[pf_slot]  <= 1'b0;
      q_cache[pf_slot] <= 1'b0;
      q_buf[pf_slot]   <= 1'b1;
      q_num[pf_slot]   <= grant_num;
    end
    if (mem_done) begin
      fill_line_r <= q_line[head];
      fill_num_r  <= q_num[head];
      fill_data_r <= mem_data;
    end
  end

endmodule

// File: design/stream_control.sv
module stream_control
  import dcache_pkg::*;
#(
  parameter int NUM_BUFFERS = 4
) (
  input  logic      clock,
  input  logic      reset,
  input  logic      rd_en,
  input  line_t     rd_line,
  input  logic      rd_hit,
  input  logic      miss_taken,
  output logic      miss_en,
  output line_t     miss_line,
  output logic      move_en,
  output line_t     move_line,
  output data_t     move_data,
  stream_if.control sc
);

  localparam int BW = $clog2(NUM_BUFFERS);

  // pseudo-LRU tree, a set bit points at the right half as older
  logic [NUM_BUFFERS-2:0] lru;
  logic [BW-1:0]          hit_num;
  logic [BW-1:0]          victim;
  logic                   cache_miss;
  logic                   buffer_hit;

  function automatic logic [BW-1:0] lru_victim(input logic [NUM_BUFFERS-2:0] tree);
    int            node;
    logic [BW-1:0] v;
    node = 0;
    v    = '0;
    for (int l = 0; l < BW; l++) begin
      v[BW-1-l] = tree[node];
      node      = 2 * node + 1 + int'(tree[node]);
    end
    return v;
  endfunction

  // point every node on the path away from the used buffer
  function automatic logic [NUM_BUFFERS-2:0] lru_touch(input logic [NUM_BUFFERS-2:0] tree,
                                                       input logic [BW-1:0] idx);
    int                     node;
    logic [NUM_BUFFERS-2:0] t;
    node = 0;
    t    = tree;
    for (int l = 0; l < BW; l++) begin
      t[node] = ~idx[BW-1-l];
      node    = 2 * node + 1 + int'(idx[BW-1-l]);
    end
    return t;
  endfunction

  always_comb begin
    hit_num = '0;
    for (int b = NUM_BUFFERS - 1; b >= 0; b--) begin
      if (sc.hit[b]) hit_num = BW'(b);
    end
  end

  assign victim     = lru_victim(lru);
  assign cache_miss = rd_en && !rd_hit;
  assign buffer_hit = cache_miss && (|sc.hit);

  assign sc.lookup_line = rd_line;
  assign sc.alloc_line  = rd_line;
  assign sc.take        = buffer_hit ? (NUM_BUFFERS'(1) << hit_num) : '0;
  assign sc.alloc       = (miss_en && miss_taken) ? (NUM_BUFFERS'(1) << victim) : '0;

  assign move_en   = buffer_hit;
  assign move_line = rd_line;
  assign move_data = sc.hit_data[hit_num];

  assign miss_en   = cache_miss && !(|sc.hit);
  assign miss_line = rd_line;

  always_ff @(posedge clock) begin
    if (reset) begin
      lru <= '0;
    end else if (buffer_hit) begin
      lru <= lru_touch(lru, hit_num);
    end else if (miss_en && miss_taken) begin
      lru <= lru_touch(lru, victim);
    end
  end

endmodule

// File: design/stream_buffer.sv
module stream_buffer
  import dcache_pkg::*;
#(
  parameter int BUFFER_DEPTH = 4,
  parameter int BUFFER_ID    = 0
) (
  input logic      clock,
  input logic      reset,
  stream_if.buffer sb
);

  localparam int IW = $clog2(BUFFER_DEPTH);
  localparam int CW = $clog2(BUFFER_DEPTH + 1);

  // entry 0 is the oldest; filled entries form a prefix
  line_t          e_line [BUFFER_DEPTH];
  data_t          e_data [BUFFER_DEPTH];
  logic [CW-1:0]  used;
  logic [CW-1:0]  filled;
  line_t          next_line;
  logic           active;

  line_t          n_line [BUFFER_DEPTH];
  data_t          n_data [BUFFER_DEPTH];
  logic [CW-1:0]  n_used;
  logic [CW-1:0]  n_filled;
  line_t          n_next;
  logic           n_active;

  logic           hit_any;
  logic [IW-1:0]  hit_idx;

  always_comb begin
    hit_any = 1'b0;
    hit_idx = '0;
    for (int i = BUFFER_DEPTH - 1; i >= 0; i--) begin
      if (CW'(i) < filled && e_line[i] == sb.lookup_line) begin
        hit_any = 1'b1;
        hit_idx = IW'(i);
      end
    end
  end

  assign sb.hit[BUFFER_ID]      = hit_any;
  assign sb.hit_data[BUFFER_ID] = e_data[hit_idx];
  assign sb.req[BUFFER_ID]      = active && (used < CW'(BUFFER_DEPTH));
  assign sb.req_line[BUFFER_ID] = next_line;

  always_comb begin
    n_line   = e_line;
    n_data   = e_data;
    n_used   = used;
    n_filled = filled;
    n_next   = next_line;
    n_active = active;
    // memory data lands in the oldest pending entry
    if (sb.fill[BUFFER_ID]) begin
      n_data[filled[IW-1:0]] = sb.fill_data;
      n_filled = filled + 1'b1;
    end
    if (sb.grant[BUFFER_ID]) begin
      n_line[used[IW-1:0]] = next_line;
      n_used = used + 1'b1;
      n_next = next_line + 1'b1;
    end
    // drop the taken entry and everything older
    if (sb.take[BUFFER_ID]) begin
      for (int i = 0; i < BUFFER_DEPTH; i++) begin
        if (i + int'(hit_idx) + 1 < BUFFER_DEPTH) begin
          n_line[i] = n_line[i + int'(hit_idx) + 1];
          n_data[i] = n_data[i + int'(hit_idx) + 1];
        end
      end
      n_used   = n_used - (CW'(hit_idx) + 1'b1);
      n_filled = n_filled - (CW'(hit_idx) + 1'b1);
    end
    if (sb.alloc[BUFFER_ID]) begin
      n_used   = '0;
      n_filled = '0;
      n_next   = sb.alloc_line + 1'b1;
      n_active = 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      used      <= '0;
      filled    <= '0;
      next_line <= '0;
      active    <= 1'b0;
    end else begin
      used      <= n_used;
      filled    <= n_filled;
      next_line <= n_next;
      active    <= n_active;
    end
  end

  always_ff @(posedge clock) begin
    e_line <= n_line;
    e_data <= n_data;
  end

endmodule

// File: design/line_store.sv
module line_store
  import dcache_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  line_t rd_line,
  input  logic  wr_en,
  input  line_t wr_line,
  input  data_t wr_data,
  input  logic  move_en,
  input  line_t move_line,
  input  data_t move_data,
  input  logic  fill_en,
  input  line_t fill_line,
  input  data_t fill_data,
  output logic  rd_hit,
  output data_t rd_data
);

  logic [NUM_SETS-1:0] valid;
  cache_tag_t          tags [NUM_SETS];
  data_t               lines [NUM_SETS];

  function automatic set_idx_t idx_of(input line_t line);
    return line[$bits(set_idx_t)-1:0];
  endfunction

  function automatic cache_tag_t tag_of(input line_t line);
    return line[$bits(line_t)-1:$bits(set_idx_t)];
  endfunction

  // combinational lookup
  assign rd_hit  = valid[idx_of(rd_line)] && (tags[idx_of(rd_line)] == tag_of(rd_line));
  assign rd_data = lines[idx_of(rd_line)];

  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= '0;
    end else begin
      if (fill_en) valid[idx_of(fill_line)] <= 1'b1;
      if (move_en) valid[idx_of(move_line)] <= 1'b1;
      if (wr_en)   valid[idx_of(wr_line)]   <= 1'b1;
    end
  end

  // later writes win, so a store beats a move beats a fill
  always_ff @(posedge clock) begin
    if (fill_en) begin
      tags[idx_of(fill_line)]  <= tag_of(fill_line);
      lines[idx_of(fill_line)] <= fill_data;
    end
    if (move_en) begin
      tags[idx_of(move_line)]  <= tag_of(move_line);
      lines[idx_of(move_line)] <= move_data;
    end
    if (wr_en) begin
      tags[idx_of(wr_line)]  <= tag_of(wr_line);
      lines[idx_of(wr_line)] <= wr_data;
    end
  end

endmodule

// File: design/stream_if.sv
interface stream_if
  import dcache_pkg::*;
#(
  parameter int NUM_BUFFERS = 4
) ();

  // from the control
  line_t                  lookup_line;
  logic [NUM_BUFFERS-1:0] alloc;
  line_t                  alloc_line;
  logic [NUM_BUFFERS-1:0] take;

  // from the buffers, one slot each
  logic [NUM_BUFFERS-1:0] hit;
  data_t                  hit_data [NUM_BUFFERS];
  logic [NUM_BUFFERS-1:0] req;
  line_t                  req_line [NUM_BUFFERS];

  // from the request queue
  logic [NUM_BUFFERS-1:0] grant;
  logic [NUM_BUFFERS-1:0] fill;
  data_t                  fill_data;

  modport control (
    output lookup_line, alloc, alloc_line, take,
    input  hit, hit_data
  );

  modport buffer (
    input  lookup_line, alloc, alloc_line, take, grant, fill, fill_data,
    output hit, hit_data, req, req_line
  );

  // alloc is seen here so that stale prefetches are dropped
  modport queue (
    input  req, req_line, alloc,
    output grant, fill, fill_data
  );

endinterface

// File: design/dcache_pkg.sv
package dcache_pkg;

  ////////////////////
  // addresses and data
  ////////////////////

  // byte address from the processor
  typedef logic [31:0] addr_t;

  // one cache line, 8 bytes
  typedef logic [63:0] data_t;

  // byte address without the 3 offset bits
  typedef logic [28:0] line_t;

  ////////////////////
  // cache geometry
  ////////////////////

  localparam int NUM_SETS = 32;

  // low line bits pick the set, the rest is stored as tag
  typedef logic [4:0]  set_idx_t;
  typedef logic [23:0] cache_tag_t;

  ////////////////////
  // memory bus
  ////////////////////

  // transaction tag handed out by memory, zero means none
  typedef logic [3:0] mem_tag_t;

  typedef logic [1:0] bus_cmd_t;

  localparam bus_cmd_t BUS_NONE = 2'd0;
  localparam bus_cmd_t BUS_LOAD = 2'd1;

endpackage
